//--- Bender.yml
package:
  name: uart_multi

sources:
  # packages first, then the design bottom up
  - hw/uart_bus_pkg.sv
  - hw/uart_line_pkg.sv
  - hw/wb_uart_decoder.sv
  - hw/uart_channel.sv
  - hw/uart_read_mux.sv
  - hw/uart_multi_top.sv

  - target: simulation
    files:
      - verification/uart_multi_assert.sv
      - verification/uart_multi_tb.sv

//--- compile.f
hw/uart_bus_pkg.sv
hw/uart_line_pkg.sv
hw/wb_uart_decoder.sv
hw/uart_channel.sv
hw/uart_read_mux.sv
hw/uart_multi_top.sv
verification/uart_multi_assert.sv
verification/uart_multi_tb.sv

//--- hw/uart_bus_pkg.sv
// ==========================================================
// bus side constants, only the low byte of the data bus is live
// register map is 4 byte registers per channel, 16 channels max
// ==========================================================
package uart_bus_pkg;

    // wishbone widths
    localparam int bus_addr_w = 8;  // word address
    localparam int bus_data_w = 32;
    localparam int reg_data_w = 8;  // upper bus bits read as zero

    // address split
    localparam int reg_off_w  = 2;
    localparam int chan_sel_w = 4;  // upper bits of wb_adr
    localparam int num_regs   = 1 << reg_off_w;

    // register offsets within a channel
    localparam logic [reg_off_w-1:0] off_tx_data = 2'd0;  // r/w
    localparam logic [reg_off_w-1:0] off_cmd     = 2'd1;  // write only
    localparam logic [reg_off_w-1:0] off_status  = 2'd2;  // read only
    localparam logic [reg_off_w-1:0] off_rx_data = 2'd3;  // read only

    // status register bits
    localparam int stat_tx_busy    = 0;
    localparam int stat_rx_valid   = 1;
    localparam int stat_rx_overrun = 2;

    // command opcodes, unknown values behave as nop
    typedef enum logic [7:0] {
        cmd_nop      = 8'd0,
        cmd_send     = 8'd1,  // start a frame
        cmd_clear_rx = 8'd2   // drop rx_valid and overrun
    } uart_cmd_e;

endpackage

//--- hw/uart_channel.sv
// ==========================================================
// one 8n1 channel, baud fixed by clks_per_bit (min 4)
// send while busy is ignored, no rx framing check
// ==========================================================
module uart_channel #(
    parameter int clks_per_bit = 104
) (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic                                                      wr_en,
    input  logic [uart_bus_pkg::reg_off_w-1:0]                        wr_off,
    input  logic [uart_bus_pkg::reg_data_w-1:0]                       wr_data,
    input  logic                                                      rx,
    output logic                                                      tx,
    output logic [uart_bus_pkg::num_regs-1:0][uart_bus_pkg::reg_data_w-1:0] rd_data,
    output logic                                                      rx_valid
);
    import uart_bus_pkg::*;
    import uart_line_pkg::*;

    localparam int cnt_w    = $clog2(clks_per_bit);
    localparam int half_bit = clks_per_bit / 2;
    localparam logic [cnt_w-1:0]       bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0]       half_last = cnt_w'(half_bit - 1);
    localparam logic [frame_idx_w-1:0] idx_last  = frame_idx_w'(frame_data_bits - 1);

    logic [reg_data_w-1:0]      tx_data_q;
    logic [reg_data_w-1:0]      rx_data_q;
    logic [reg_data_w-1:0]      status;
    logic                       overrun;
    logic                       tx_busy;
    uart_cmd_e                  cmd;
    logic                       do_send;
    logic                       do_clear;
    tx_state_e                  tx_state;
    logic [cnt_w-1:0]           tx_cnt;
    logic [frame_idx_w-1:0]     tx_bit;
    logic [frame_data_bits-1:0] tx_shift;
    rx_state_e                  rx_state;
    logic [cnt_w-1:0]           rx_cnt;
    logic [frame_idx_w-1:0]     rx_bit;
    logic [frame_data_bits-1:0] rx_shift;
    logic                       rx_meta;
    logic                       rx_sync;

    // command decode
    assign cmd = uart_cmd_e'(wr_data);

    always_comb
    begin
        do_send  = 1'b0;
        do_clear = 1'b0;
        if (wr_en && wr_off == off_cmd)
        begin
            case (cmd)
                cmd_send:     do_send  = 1'b1;
                cmd_clear_rx: do_clear = 1'b1;
                default:      ;  // nop and unknown opcodes
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            tx_data_q <= '0;
        else if (wr_en && wr_off == off_tx_data)
            tx_data_q <= wr_data;
    end

    assign tx_busy = (tx_state != tx_idle);

    // transmit, tx is a flop so the line is glitch free
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_state <= tx_idle;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_shift <= '0;
            tx       <= line_idle;
        end
        else if (tx_state == tx_idle)
        begin
            if (do_send)
            begin
                tx_state <= tx_start;
                tx_cnt   <= '0;
                tx_shift <= tx_data_q;  // snapshot, tx_data may change
                tx       <= line_start;  // low the cycle after the strobe
            end
        end
        else if (tx_cnt != bit_last)
            tx_cnt <= tx_cnt + 1'b1;
        else
        begin
            tx_cnt <= '0;  // bit boundary
            case (tx_state)
                tx_start:
                begin
                    tx_state <= tx_data;
                    tx_bit   <= '0;
                    tx       <= tx_shift[0];  // lsb first
                    tx_shift <= tx_shift >> 1;
                end
                tx_data:
                begin
                    if (tx_bit == idx_last)
                    begin
                        tx_state <= tx_stop;
                        tx       <= line_stop;
                    end
                    else
                    begin
                        tx_bit   <= tx_bit + 1'b1;
                        tx       <= tx_shift[0];
                        tx_shift <= tx_shift >> 1;
                    end
                end
                default: tx_state <= tx_idle;  // busy drops as stop bit ends
            endcase
        end
    end

    // two flop synchronizer, idles high
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_meta <= line_idle;
            rx_sync <= line_idle;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // receive, every sample taken near the bit middle
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_state  <= rx_idle;
            rx_cnt    <= '0;
            rx_bit    <= '0;
            rx_shift  <= '0;
            rx_data_q <= '0;
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
        end
        else
        begin
            if (do_clear)
            begin
                rx_valid <= 1'b0;
                overrun  <= 1'b0;
            end
            case (rx_state)
                rx_idle:
                begin
                    rx_cnt <= '0;
                    if (rx_sync == line_start)
                        rx_state <= rx_start;
                end
                rx_start:
                begin
                    if (rx_cnt != half_last)
                        rx_cnt <= rx_cnt + 1'b1;
                    else
                    begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        // a short glitch falls back to idle
                        rx_state <= (rx_sync == line_start) ? rx_data : rx_idle;
                    end
                end
                rx_data:
                begin
                    if (rx_cnt != bit_last)
                        rx_cnt <= rx_cnt + 1'b1;
                    else
                    begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync, rx_shift[frame_data_bits-1:1]};
                        if (rx_bit == idx_last)
                            rx_state <= rx_stop;
                        else
                            rx_bit <= rx_bit + 1'b1;
                    end
                end
                default:
                begin
                    if (rx_cnt != bit_last)
                        rx_cnt <= rx_cnt + 1'b1;
                    else
                    begin
                        // middle of stop bit, frame done
                        rx_state  <= rx_idle;
                        rx_cnt    <= '0;
                        rx_data_q <= rx_shift;  // newest frame always wins
                        rx_valid  <= 1'b1;
                        if (rx_valid && !do_clear)
                            overrun <= 1'b1;
                    end
                end
            endcase
        end
    end

    // register views, the mux picks by offset
    always_comb
    begin
        status                  = '0;
        status[stat_tx_busy]    = tx_busy;
        status[stat_rx_valid]   = rx_valid;
        status[stat_rx_overrun] = overrun;
        rd_data                 = '0;  // command view stays zero
        rd_data[off_tx_data]    = tx_data_q;
        rd_data[off_status]     = status;
        rd_data[off_rx_data]    = rx_data_q;
    end

endmodule

//--- hw/uart_line_pkg.sv
// ==========================================================
// 8n1 frame only, no parity and a single stop bit
// ==========================================================
package uart_line_pkg;

    // frame shape, data goes lsb first
    localparam int frame_data_bits = 8;
    localparam int frame_idx_w     = $clog2(frame_data_bits);

    // line levels
    localparam logic line_idle  = 1'b1;
    localparam logic line_start = 1'b0;
    localparam logic line_stop  = 1'b1;

    // transmit fsm
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    // receive fsm
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,  // waiting for middle of start bit
        rx_data,
        rx_stop
    } rx_state_e;

endpackage

//--- hw/uart_multi_top.sv
// ==========================================================
// num_channels 1..16, clks_per_bit >= 4, one shared irq
// ==========================================================
module uart_multi_top #(
    parameter int num_channels = 4,
    parameter int clks_per_bit = 104
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [uart_bus_pkg::bus_addr_w-1:0] wb_adr,
    input  logic [uart_bus_pkg::bus_data_w-1:0] wb_dat_w,
    output logic [uart_bus_pkg::bus_data_w-1:0] wb_dat_r,
    output logic                                wb_ack,
    input  logic [num_channels-1:0]             rx,
    output logic [num_channels-1:0]             tx,
    output logic                                irq
);
    import uart_bus_pkg::*;

    logic [num_channels-1:0]                           wr_en;
    logic [reg_off_w-1:0]                              wr_off;
    logic [reg_data_w-1:0]                             wr_data;
    logic [chan_sel_w-1:0]                             rd_sel;
    logic [reg_off_w-1:0]                              rd_off;
    logic                                              rd_hit;
    logic                                              rd_strobe;
    logic [num_channels-1:0][num_regs-1:0][reg_data_w-1:0] rd_data;
    logic [num_channels-1:0]                           rx_valid;

    wb_uart_decoder #(
        .num_channels(num_channels)
    ) u_decoder (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wr_en    (wr_en),
        .wr_off   (wr_off),
        .wr_data  (wr_data),
        .rd_sel   (rd_sel),
        .rd_off   (rd_off),
        .rd_hit   (rd_hit),
        .rd_strobe(rd_strobe)
    );

    // identical channels, write data is broadcast
    for (genvar i = 0; i < num_channels; i++)
    begin : g_chan
        uart_channel #(
            .clks_per_bit(clks_per_bit)
        ) u_channel (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (wr_en[i]),
            .wr_off  (wr_off),
            .wr_data (wr_data),
            .rx      (rx[i]),
            .tx      (tx[i]),
            .rd_data (rd_data[i]),
            .rx_valid(rx_valid[i])
        );
    end

    uart_read_mux #(
        .num_channels(num_channels)
    ) u_read_mux (
        .clk      (clk),
        .reset    (reset),
        .rd_data  (rd_data),
        .rx_valid (rx_valid),
        .rd_sel   (rd_sel),
        .rd_off   (rd_off),
        .rd_hit   (rd_hit),
        .rd_strobe(rd_strobe),
        .wb_dat_r (wb_dat_r),
        .irq      (irq)
    );

endmodule

//--- hw/uart_read_mux.sv
// ==========================================================
// read data is valid in the ack cycle only, irq lags by one
// ==========================================================
module uart_read_mux #(
    parameter int num_channels = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic [num_channels-1:0][uart_bus_pkg::num_regs-1:0][uart_bus_pkg::reg_data_w-1:0]
                 rd_data,
    input  logic [num_channels-1:0]             rx_valid,
    input  logic [uart_bus_pkg::chan_sel_w-1:0] rd_sel,
    input  logic [uart_bus_pkg::reg_off_w-1:0]  rd_off,
    input  logic                                rd_hit,
    input  logic                                rd_strobe,
    output logic [uart_bus_pkg::bus_data_w-1:0] wb_dat_r,
    output logic                                irq
);
    import uart_bus_pkg::*;

    logic [reg_data_w-1:0] sel_byte;

    // pick channel then offset, zero for a bad index
    always_comb
    begin
        sel_byte = '0;
        for (int i = 0; i < num_channels; i++)
        begin
            if (rd_hit && rd_sel == chan_sel_w'(i))
                sel_byte = rd_data[i][rd_off];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wb_dat_r <= '0;
            irq      <= 1'b0;
        end
        else
        begin
            if (rd_strobe)
                wb_dat_r <= bus_data_w'(sel_byte);  // zero extended
            irq <= |rx_valid;  // any channel holding a byte
        end
    end

endmodule

//--- hw/wb_uart_decoder.sv
// ==========================================================
// classic slave, fixed 2 cycle access, ack never back to back
// out of range channels are acked, writes dropped, reads zero
// ==========================================================
module wb_uart_decoder #(
    parameter int num_channels = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [uart_bus_pkg::bus_addr_w-1:0] wb_adr,
    input  logic [uart_bus_pkg::bus_data_w-1:0] wb_dat_w,
    output logic                                wb_ack,
    output logic [num_channels-1:0]             wr_en,
    output logic [uart_bus_pkg::reg_off_w-1:0]  wr_off,
    output logic [uart_bus_pkg::reg_data_w-1:0] wr_data,
    output logic [uart_bus_pkg::chan_sel_w-1:0] rd_sel,
    output logic [uart_bus_pkg::reg_off_w-1:0]  rd_off,
    output logic                                rd_hit,
    output logic                                rd_strobe
);
    import uart_bus_pkg::*;

    logic                  new_access;
    logic [chan_sel_w-1:0] chan;
    logic [reg_off_w-1:0]  off;
    logic                  hit;

    // a held stb during the ack cycle is not a second access
    assign new_access = wb_cyc && wb_stb && !wb_ack;

    assign chan = wb_adr[bus_addr_w-1 -: chan_sel_w];  // upper bits
    assign off  = wb_adr[reg_off_w-1:0];               // lowest bits
    assign hit  = int'(chan) < num_channels;

    // read select goes out in the accepting cycle
    // the mux registers it so data lines up with ack
    assign rd_sel    = chan;
    assign rd_off    = off;
    assign rd_hit    = hit;
    assign rd_strobe = new_access && !wb_we;

    // ack and write strobes land in the same cycle
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wb_ack <= 1'b0;
            wr_en  <= '0;
        end
        else
        begin
            wb_ack <= new_access;  // one cycle pulse
            for (int i = 0; i < num_channels; i++)
            begin
                // one hot, nothing fires for a bad index
                wr_en[i] <= new_access && wb_we && (chan == chan_sel_w'(i));
            end
        end
    end

    // broadcast payload, only qualified by wr_en
    always_ff @(posedge clk)
    begin
        if (new_access)
        begin
            wr_off  <= off;
            wr_data <= wb_dat_w[reg_data_w-1:0];  // low byte only
        end
    end

endmodule

//--- verification/uart_multi_assert.sv
// ==========================================================
// bound into uart_multi_top, tx_busy taken from status views
// ==========================================================
module uart_multi_assert #(
    parameter int num_channels = 4
) (
    input logic                          clk,
    input logic                          reset,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [num_channels-1:0]       tx,
    input logic [num_channels-1:0]       rx_valid,
    input logic                          irq,
    input logic [num_channels-1:0][uart_bus_pkg::num_regs-1:0][uart_bus_pkg::reg_data_w-1:0]
                                         rd_data
);
    import uart_bus_pkg::*;

    logic [num_channels-1:0] tx_busy;
    int                      fail_count = 0;  // read by the testbench

    always_comb
    begin
        for (int i = 0; i < num_channels; i++)
            tx_busy[i] = rd_data[i][off_status][stat_tx_busy];  // tx fsm not idle
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!reset)
        wb_ack |-> (wb_cyc && wb_stb))
    else
    begin
        fail_count++;
        $error("ack raised without cyc and stb");
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!reset)
        wb_ack |=> !wb_ack)  // never two in a row
    else
    begin
        fail_count++;
        $error("ack high for two cycles");
    end

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!reset)
        &(tx | tx_busy))
    else
    begin
        fail_count++;
        $error("tx low on an idle channel");
    end

    a_irq_follows: assert property (@(posedge clk) disable iff (!reset)
        irq == $past(|rx_valid))
    else
    begin
        fail_count++;
        $error("irq differs from the or of rx_valid one cycle before");
    end

endmodule

bind uart_multi_top uart_multi_assert #(
    .num_channels(num_channels)
) u_assert (
    .clk     (clk),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .tx      (tx),
    .rx_valid(rx_valid),
    .irq     (irq),
    .rd_data (rd_data)
);

//--- verification/uart_multi_tb.sv
// ==========================================================
// 4 channels at 8 clocks per bit, channels 0..2 looped back
// channel 3 rx is driven here, index 9 is out of range
// ==========================================================
module uart_multi_tb;
    import uart_bus_pkg::*;
    import uart_line_pkg::*;

    localparam int num_channels = 4;
    localparam int clks_per_bit = 8;
    localparam int max_polls    = 10 * clks_per_bit;  // status reads before giving up

    typedef enum int { k_register, k_loopback, k_bad_channel, k_overrun } test_kind_e;

    logic                    clk;
    logic                    reset;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [bus_addr_w-1:0]   wb_adr;
    logic [bus_data_w-1:0]   wb_dat_w;
    logic [bus_data_w-1:0]   wb_dat_r;
    logic                    wb_ack;
    logic [num_channels-1:0] rx;
    logic [num_channels-1:0] tx;
    logic                    rx_ext;  // serial source for channel 3
    logic                    irq;

    // test table, one slot per column
    string      t_name[$];
    test_kind_e t_kind[$];
    int         t_chan[$];
    int         t_chan2[$];  // second sender, -1 when unused
    logic [7:0] t_data[$];
    logic [7:0] t_data2[$];
    logic [7:0] t_exp[$];

    logic [7:0]  tx_shadow [num_channels];  // last tx_data written per channel
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    assign rx = {rx_ext, tx[2:0]};  // loopback on 0..2

    uart_multi_top #(
        .num_channels(num_channels),
        .clks_per_bit(clks_per_bit)
    ) u_uart_multi_top (
        .clk     (clk),
        .reset   (reset),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .rx      (rx),
        .tx      (tx),
        .irq     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout after %0d cycles with %0d errors so far", cycles, errors);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic void add_test(string name, test_kind_e kind, int chan, logic [7:0] data,
                                     int chan2, logic [7:0] data2, logic [7:0] exp);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_chan.push_back(chan);
        t_data.push_back(data);
        t_chan2.push_back(chan2);
        t_data2.push_back(data2);
        t_exp.push_back(exp);
    endfunction

    task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    // one classic cycle, entered and left on a falling edge
    task automatic bus_access(input logic we, input int ch, input logic [1:0] off,
                              input logic [7:0] wdata, output logic [31:0] rdata);
        logic [bus_addr_w-1:0] adr;
        int                    waited;
        adr = '0;
        adr[bus_addr_w-1 -: chan_sel_w] = chan_sel_w'(ch);  // channel in the top bits
        adr[reg_off_w-1:0] = off;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = {24'($urandom), wdata};  // junk in the dead upper bits
        waited   = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_ack && waited < 8);
        if (!wb_ack)
        begin
            errors++;
            $display("no ack for access to channel %0d offset %0d", ch, off);
        end
        else if (waited != 1)
        begin
            errors++;
            $display("mismatch ack latency: expected 1, actual %0d", waited);
        end
        rdata = wb_dat_r;
        @(negedge clk);  // hold through the ack edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(int ch, logic [1:0] off, logic [7:0] data);
        logic [31:0] unused;
        bus_access(1'b1, ch, off, data, unused);
    endtask

    task automatic wb_read(int ch, logic [1:0] off, output logic [31:0] data);
        bus_access(1'b0, ch, off, 8'h00, data);
    endtask

    // poll status until one bit reaches the wanted level
    task automatic wait_status(int ch, int bit_pos, logic level, string name);
        logic [31:0] st;
        int          polls;
        polls = 0;
        wb_read(ch, off_status, st);
        while (st[bit_pos] !== level && polls < max_polls)
        begin
            wb_read(ch, off_status, st);
            polls++;
        end
        if (st[bit_pos] !== level)
        begin
            errors++;
            $display("%s: channel %0d status bit %0d never reached %0b", name, ch, bit_pos, level);
        end
    endtask

    // mid-bit samples counted from the start bit's falling edge
    task automatic capture_frame(int ch, logic [7:0] data, string name);
        logic [frame_data_bits+1:0] exp_frame;
        logic [frame_data_bits+1:0] got;
        exp_frame = {1'b1, data, 1'b0};  // stop, byte lsb first, start
        wait (tx[ch] == 1'b0);
        repeat (clks_per_bit / 2) @(negedge clk);
        got[0] = tx[ch];
        for (int i = 1; i < frame_data_bits + 2; i++)
        begin
            repeat (clks_per_bit) @(negedge clk);
            got[i] = tx[ch];
        end
        compare({name, " tx frame"}, 32'(exp_frame), 32'(got));
    endtask

    task automatic send_serial(logic [7:0] data);
        logic [frame_data_bits+1:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < frame_data_bits + 2; i++)
        begin
            rx_ext = frame[i];
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic run_register(int idx);
        logic [31:0] rd;
        wb_read(t_chan[idx], off_status, rd);
        compare({t_name[idx], " status"}, 0, rd);
        wb_write(t_chan[idx], off_tx_data, t_data[idx]);
        tx_shadow[t_chan[idx]] = t_data[idx];
        wb_read(t_chan[idx], off_tx_data, rd);
        compare({t_name[idx], " tx_data"}, 32'(t_exp[idx]), rd);
        wb_read(t_chan[idx], off_cmd, rd);  // write only register
        compare({t_name[idx], " cmd"}, 0, rd);
    endtask

    task automatic run_loopback(int idx);
        int          ch;
        int          ch2;
        string       nm;
        logic [31:0] rd;
        ch  = t_chan[idx];
        ch2 = t_chan2[idx];
        nm  = t_name[idx];
        wb_write(ch, off_tx_data, t_data[idx]);
        tx_shadow[ch] = t_data[idx];
        if (ch2 >= 0)
        begin
            wb_write(ch2, off_tx_data, t_data2[idx]);
            tx_shadow[ch2] = t_data2[idx];
        end
        fork
            capture_frame(ch, t_data[idx], nm);
            begin
                wb_write(ch, off_cmd, 8'(cmd_send));
                if (ch2 >= 0)
                    wb_write(ch2, off_cmd, 8'(cmd_send));  // overlaps the first frame
                wb_read(ch, off_status, rd);
                compare({nm, " tx_busy"}, 1, 32'(rd[stat_tx_busy]));
            end
        join
        wait_status(ch, stat_rx_valid, 1'b1, nm);
        wb_read(ch, off_rx_data, rd);
        compare({nm, " rx_data"}, 32'(t_exp[idx]), rd);
        compare({nm, " irq"}, 1, 32'(irq));
        if (ch2 >= 0)
        begin
            wait_status(ch2, stat_rx_valid, 1'b1, nm);
            wb_read(ch2, off_rx_data, rd);
            compare({nm, " second rx_data"}, 32'(t_data2[idx]), rd);
            wait_status(ch2, stat_tx_busy, 1'b0, nm);
            wb_write(ch2, off_cmd, 8'(cmd_clear_rx));
        end
        wait_status(ch, stat_tx_busy, 1'b0, nm);
        wb_write(ch, off_cmd, 8'(cmd_clear_rx));
        wb_read(ch, off_status, rd);
        compare({nm, " status after clear"}, 0, rd);
        compare({nm, " irq after clear"}, 0, 32'(irq));
    endtask

    task automatic run_overrun(int idx);
        logic [31:0] rd;
        send_serial(t_data[idx]);
        send_serial(t_data2[idx]);  // no clear in between
        repeat (2 * clks_per_bit) @(negedge clk);
        wb_read(t_chan[idx], off_status, rd);
        compare({t_name[idx], " status"}, (1 << stat_rx_valid) | (1 << stat_rx_overrun), rd);
        wb_read(t_chan[idx], off_rx_data, rd);
        compare({t_name[idx], " rx_data"}, 32'(t_exp[idx]), rd);
        compare({t_name[idx], " irq"}, 1, 32'(irq));
        wb_write(t_chan[idx], off_cmd, 8'(cmd_clear_rx));
        wb_read(t_chan[idx], off_status, rd);
        compare({t_name[idx], " status after clear"}, 0, rd);
    endtask

    task automatic run_bad_channel(int idx);
        logic [31:0] rd;
        wb_write(t_chan[idx], off_tx_data, t_data[idx]);
        wb_write(t_chan[idx], off_cmd, 8'(cmd_send));
        wb_read(t_chan[idx], off_tx_data, rd);
        compare({t_name[idx], " tx_data"}, 32'(t_exp[idx]), rd);
        wb_read(t_chan[idx], off_status, rd);
        compare({t_name[idx], " status"}, 32'(t_exp[idx]), rd);
        for (int c = 0; c < num_channels; c++)
        begin
            wb_read(c, off_tx_data, rd);  // real channels untouched
            compare($sformatf("%s ch%0d tx_data", t_name[idx], c), 32'(tx_shadow[c]), rd);
            wb_read(c, off_status, rd);
            compare($sformatf("%s ch%0d status", t_name[idx], c), 0, rd);
        end
    endtask

    initial
    begin
        reset    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rx_ext   = 1'b1;  // idle line
        foreach (tx_shadow[c])
            tx_shadow[c] = 8'h00;

        // name, kind, chan, data, chan2, data2, expected
        add_test("reg_ch0", k_register, 0, 8'ha5, -1, 8'h00, 8'ha5);
        add_test("reg_ch3", k_register, 3, 8'h5a, -1, 8'h00, 8'h5a);
        add_test("loop_ch1_frame", k_loopback, 1, 8'h4d, -1, 8'h00, 8'h4d);
        add_test("loop_ch0", k_loopback, 0, 8'h81, -1, 8'h00, 8'h81);
        begin
            logic [7:0] first_byte;
            logic [7:0] second_byte;
            first_byte  = 8'($urandom(32'hdad4ae96));  // seeds the generator, first draw
            second_byte = 8'($urandom);
            if (second_byte == first_byte)
                second_byte = ~first_byte;  // replacement must be visible
            add_test("ext_overrun_ch3", k_overrun, 3, first_byte, -1, second_byte, second_byte);
        end
        add_test("bad_channel_9", k_bad_channel, 9, 8'h77, -1, 8'h00, 8'h00);
        add_test("pair_ch0_ch2", k_loopback, 0, 8'h3c, 2, 8'hc3, 8'h3c);
        cycle_limit = t_name.size() * (2 * 10 * clks_per_bit + 200);

        repeat (10) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        compare("reset tx", 32'({num_channels{1'b1}}), 32'(tx));
        compare("reset ack", 0, 32'(wb_ack));
        compare("reset irq", 0, 32'(irq));

        foreach (t_name[i])
        begin
            case (t_kind[i])
                k_register:    run_register(i);
                k_loopback:    run_loopback(i);
                k_overrun:     run_overrun(i);
                default:       run_bad_channel(i);
            endcase
        end

        $display("errors: checks %0d, assertions %0d", errors,
                 u_uart_multi_top.u_assert.fail_count);
        if (errors == 0 && u_uart_multi_top.u_assert.fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
